//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int XLEN      = 32;
  localparam int ADDR_W    = 32;
  localparam int BUS_BYTES = 8;
  localparam int MEM_WORDS = 256;
  localparam int LANE_W    = $clog2(BUS_BYTES);
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  typedef logic [XLEN-1:0]        reg_data_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [8*BUS_BYTES-1:0] bus_data_t;
  typedef logic [BUS_BYTES-1:0]   bus_strb_t;
  typedef logic [LANE_W-1:0]      lane_t;
  typedef logic [MEM_IDX_W-1:0]   mem_idx_t;

  typedef logic [3:0] axi_id_t;
  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

  typedef enum logic [3:0] {
    LSU_LB  = 4'd0,
    LSU_LH  = 4'd1,
    LSU_LW  = 4'd2,
    LSU_LBU = 4'd3,
    LSU_LHU = 4'd4,
    LSU_SB  = 4'd5,
    LSU_SH  = 4'd6,
    LSU_SW  = 4'd7
  } lsu_op_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    CAPTURE,
    DONE
  } master_state_t;

  typedef struct packed {
    lsu_op_t   op;
    reg_data_t base;
    reg_data_t imm;
    reg_data_t wdata;
  } lsu_req_t;

  typedef struct packed {
    reg_data_t result;
    logic      err;
  } lsu_rsp_t;

  // axi channel payloads without their valid and ready.
  typedef struct packed {
    addr_t      addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    bus_data_t data;
    bus_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    addr_t      addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  typedef struct packed {
    bus_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

endpackage

`default_nettype wire

//--- logic/lsu_align.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_align import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  lsu_req_t  req_data_i,
  input  logic      capture_i,
  input  bus_data_t beat_i,
  output addr_t     bus_addr_o,
  output axi_size_t size_o,
  output logic      is_store_o,
  output logic      misaligned_o,
  output bus_data_t wbeat_o,
  output bus_strb_t wstrb_o,
  output reg_data_t result_o
);

  addr_t     eff_addr;
  lane_t     lane;
  bus_strb_t base_strb;
  bus_data_t load_bytes;
  reg_data_t load_val;

  assign eff_addr   = req_data_i.base + req_data_i.imm;
  assign lane       = eff_addr[LANE_W-1:0];
  assign bus_addr_o = {eff_addr[ADDR_W-1:LANE_W], {LANE_W{1'b0}}};

  always_comb begin
    case (req_data_i.op)
      LSU_LB, LSU_LBU, LSU_SB: size_o = 3'd0;
      LSU_LH, LSU_LHU, LSU_SH: size_o = 3'd1;
      LSU_LW, LSU_SW:          size_o = 3'd2;
      default:                 size_o = 3'd0;
    endcase
  end

  assign is_store_o = (req_data_i.op == LSU_SB) ||
                      (req_data_i.op == LSU_SH) ||
                      (req_data_i.op == LSU_SW);

  // halfwords need an even lane, words lane 0 or 4.
  always_comb begin
    case (size_o)
      3'd1:    misaligned_o = lane[0];
      3'd2:    misaligned_o = |lane[1:0];
      default: misaligned_o = 1'b0;
    endcase
  end

  always_comb begin
    case (size_o)
      3'd0:    base_strb = bus_strb_t'(8'b0000_0001);
      3'd1:    base_strb = bus_strb_t'(8'b0000_0011);
      default: base_strb = bus_strb_t'(8'b0000_1111);
    endcase
  end

  // the strobe masks off whatever lands above the stored bytes.
  assign wbeat_o = bus_data_t'(req_data_i.wdata) << {lane, 3'b000};
  assign wstrb_o = base_strb << lane;

  assign load_bytes = beat_i >> {lane, 3'b000};

  always_comb begin
    case (req_data_i.op)
      LSU_LB:  load_val = {{(XLEN-8){load_bytes[7]}}, load_bytes[7:0]};
      LSU_LBU: load_val = {{(XLEN-8){1'b0}}, load_bytes[7:0]};
      LSU_LH:  load_val = {{(XLEN-16){load_bytes[15]}}, load_bytes[15:0]};
      LSU_LHU: load_val = {{(XLEN-16){1'b0}}, load_bytes[15:0]};
      LSU_LW:  load_val = load_bytes[XLEN-1:0];
      default: load_val = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      result_o <= '0;
    end else if (capture_i) begin
      result_o <= load_val;
    end
  end

  // the master only captures read data.
  assert property (@(posedge clock) disable iff (reset) capture_i |-> !is_store_o);

endmodule

`default_nettype wire

//--- logic/lsu_axi_master.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_axi_master import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req_i,
  input  addr_t     bus_addr_i,
  input  axi_size_t size_i,
  input  logic      is_store_i,
  input  logic      misaligned_i,
  input  bus_data_t wbeat_i,
  input  bus_strb_t wstrb_i,
  input  reg_data_t result_i,
  input  logic      awready_i,
  input  logic      wready_i,
  input  axi_b_t    b_i,
  input  logic      bvalid_i,
  input  logic      arready_i,
  input  axi_r_t    r_i,
  input  logic      rvalid_i,
  output logic      ack_o,
  output lsu_rsp_t  rsp_o,
  output axi_aw_t   aw_o,
  output logic      awvalid_o,
  output axi_w_t    w_o,
  output logic      wvalid_o,
  output logic      bready_o,
  output axi_ar_t   ar_o,
  output logic      arvalid_o,
  output logic      rready_o,
  output logic      capture_o,
  output bus_data_t beat_o
);

  master_state_t state_q;
  master_state_t state_d;
  logic          aw_done_q;
  logic          w_done_q;
  logic          ar_done_q;
  logic          err_q;
  bus_data_t     beat_q;
  logic          aw_fire;
  logic          w_fire;
  logic          b_fire;
  logic          ar_fire;
  logic          r_fire;

  assign aw_o = '{addr: bus_addr_i, id: '0, len: '0, size: size_i, burst: AXI_BURST_INCR};
  assign w_o  = '{data: wbeat_i, strb: wstrb_i, last: 1'b1};
  assign ar_o = '{addr: bus_addr_i, id: '0, len: '0, size: size_i, burst: AXI_BURST_INCR};

  // aw and w go out together and each drops once it has been taken.
  assign awvalid_o = (state_q == WRITE) && !aw_done_q;
  assign wvalid_o  = (state_q == WRITE) && !w_done_q;
  assign bready_o  = (state_q == WRITE) && aw_done_q && w_done_q;
  assign arvalid_o = (state_q == READ) && !ar_done_q;
  assign rready_o  = (state_q == READ) && ar_done_q;

  assign aw_fire = awvalid_o && awready_i;
  assign w_fire  = wvalid_o && wready_i;
  assign b_fire  = bvalid_i && bready_o;
  assign ar_fire = arvalid_o && arready_i;
  assign r_fire  = rvalid_i && rready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (misaligned_i) begin
            state_d = DONE;
          end else if (is_store_i) begin
            state_d = WRITE;
          end else begin
            state_d = READ;
          end
        end
      end
      WRITE: begin
        if (b_fire) begin
          state_d = DONE;
        end
      end
      READ: begin
        if (r_fire) begin
          state_d = CAPTURE;
        end
      end
      CAPTURE: state_d = DONE;
      DONE: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      ar_done_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        ar_done_q <= 1'b0;
        if (req_i) begin
          err_q <= misaligned_i;
        end
      end
      if (aw_fire) begin
        aw_done_q <= 1'b1;
      end
      if (w_fire) begin
        w_done_q <= 1'b1;
      end
      if (ar_fire) begin
        ar_done_q <= 1'b1;
      end
      // slave errors fold into the same flag.
      if (b_fire) begin
        err_q <= (b_i.resp != AXI_RESP_OKAY);
      end
      if (r_fire) begin
        err_q <= (r_i.resp != AXI_RESP_OKAY);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (r_fire) begin
      beat_q <= r_i.data;
    end
  end

  assign capture_o = (state_q == CAPTURE);
  assign beat_o    = beat_q;

  assign ack_o = (state_q == DONE);
  assign rsp_o = '{result: result_i, err: err_q};

  assert property (@(posedge clock) disable iff (reset)
    awvalid_o && !awready_i |=> awvalid_o);

  // ack holds until the core lets go of req.
  assert property (@(posedge clock) disable iff (reset) ack_o && req_i |=> ack_o);

endmodule

`default_nettype wire

//--- logic/axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram import lsu_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  axi_aw_t aw_i,
  input  logic    awvalid_i,
  input  axi_w_t  w_i,
  input  logic    wvalid_i,
  input  logic    bready_i,
  input  axi_ar_t ar_i,
  input  logic    arvalid_i,
  input  logic    rready_i,
  output logic    awready_o,
  output logic    wready_o,
  output axi_b_t  b_o,
  output logic    bvalid_o,
  output logic    arready_o,
  output axi_r_t  r_o,
  output logic    rvalid_o
);

  bus_data_t mem [MEM_WORDS];

  addr_t     aw_addr_q;
  axi_w_t    w_q;
  logic      aw_full_q;
  logic      w_full_q;
  logic      bvalid_q;
  logic      rvalid_q;
  bus_data_t rdata_q;
  logic      aw_have;
  logic      w_have;
  logic      wr_go;
  addr_t     wr_addr;
  axi_w_t    wr_beat;
  mem_idx_t  wr_idx;
  mem_idx_t  rd_idx;

  assign awready_o = !aw_full_q && !bvalid_q;
  assign wready_o  = !w_full_q && !bvalid_q;
  assign arready_o = !rvalid_q;

  // a write may complete from the latched half or straight off the bus.
  assign aw_have = aw_full_q || (awvalid_i && awready_o);
  assign w_have  = w_full_q || (wvalid_i && wready_o);
  assign wr_go   = aw_have && w_have;
  assign wr_addr = aw_full_q ? aw_addr_q : aw_i.addr;
  assign wr_beat = w_full_q ? w_q : w_i;
  assign wr_idx  = wr_addr[LANE_W +: MEM_IDX_W];
  assign rd_idx  = ar_i.addr[LANE_W +: MEM_IDX_W];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      if (wr_go) begin
        aw_full_q <= 1'b0;
        w_full_q  <= 1'b0;
        bvalid_q  <= 1'b1;
      end else begin
        if (awvalid_i && awready_o) begin
          aw_full_q <= 1'b1;
        end
        if (wvalid_i && wready_o) begin
          w_full_q <= 1'b1;
        end
        if (bvalid_q && bready_i) begin
          bvalid_q <= 1'b0;
        end
      end
      if (arvalid_i && arready_o) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (awvalid_i && awready_o) begin
      aw_addr_q <= aw_i.addr;
    end
    if (wvalid_i && wready_o) begin
      w_q <= w_i;
    end
    if (wr_go) begin
      for (int i = 0; i < BUS_BYTES; i++) begin
        if (wr_beat.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_beat.data[8*i +: 8];
        end
      end
    end
    if (arvalid_i && arready_o) begin
      rdata_q <= mem[rd_idx];
    end
  end

  assign bvalid_o = bvalid_q;
  assign b_o      = '{resp: AXI_RESP_OKAY};
  assign rvalid_o = rvalid_q;
  assign r_o      = '{data: rdata_q, resp: AXI_RESP_OKAY, last: 1'b1};

  // single beats only.
  assert property (@(posedge clock) disable iff (reset) awvalid_i |-> aw_i.len == '0);
  assert property (@(posedge clock) disable iff (reset) arvalid_i |-> ar_i.len == '0);

endmodule

`default_nettype wire

//--- logic/lsu_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_subsys import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     req_i,
  input  lsu_req_t req_data_i,
  output logic     ack_o,
  output lsu_rsp_t rsp_o
);

  addr_t     bus_addr;
  axi_size_t size;
  logic      is_store;
  logic      misaligned;
  bus_data_t wbeat;
  bus_strb_t wstrb;
  reg_data_t result;
  logic      capture;
  bus_data_t beat;

  axi_aw_t aw;
  logic    awvalid;
  logic    awready;
  axi_w_t  w;
  logic    wvalid;
  logic    wready;
  axi_b_t  b;
  logic    bvalid;
  logic    bready;
  axi_ar_t ar;
  logic    arvalid;
  logic    arready;
  axi_r_t  r;
  logic    rvalid;
  logic    rready;

  lsu_align i_lsu_align (
    .clock        (clock),
    .reset        (reset),
    .req_data_i   (req_data_i),
    .capture_i    (capture),
    .beat_i       (beat),
    .bus_addr_o   (bus_addr),
    .size_o       (size),
    .is_store_o   (is_store),
    .misaligned_o (misaligned),
    .wbeat_o      (wbeat),
    .wstrb_o      (wstrb),
    .result_o     (result)
  );

  lsu_axi_master i_lsu_axi_master (
    .clock        (clock),
    .reset        (reset),
    .req_i        (req_i),
    .bus_addr_i   (bus_addr),
    .size_i       (size),
    .is_store_i   (is_store),
    .misaligned_i (misaligned),
    .wbeat_i      (wbeat),
    .wstrb_i      (wstrb),
    .result_i     (result),
    .awready_i    (awready),
    .wready_i     (wready),
    .b_i          (b),
    .bvalid_i     (bvalid),
    .arready_i    (arready),
    .r_i          (r),
    .rvalid_i     (rvalid),
    .ack_o        (ack_o),
    .rsp_o        (rsp_o),
    .aw_o         (aw),
    .awvalid_o    (awvalid),
    .w_o          (w),
    .wvalid_o     (wvalid),
    .bready_o     (bready),
    .ar_o         (ar),
    .arvalid_o    (arvalid),
    .rready_o     (rready),
    .capture_o    (capture),
    .beat_o       (beat)
  );

  axi_sram i_axi_sram (
    .clock     (clock),
    .reset     (reset),
    .aw_i      (aw),
    .awvalid_i (awvalid),
    .w_i       (w),
    .wvalid_i  (wvalid),
    .bready_i  (bready),
    .ar_i      (ar),
    .arvalid_i (arvalid),
    .rready_i  (rready),
    .awready_o (awready),
    .wready_o  (wready),
    .b_o       (b),
    .bvalid_o  (bvalid),
    .arready_o (arready),
    .r_o       (r),
    .rvalid_o  (rvalid)
  );

endmodule

`default_nettype wire

//--- test/lsu_model.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// byte image of the sram in byte address order.
localparam int MODEL_BYTES = MEM_WORDS * BUS_BYTES;

logic [7:0] model_mem [MODEL_BYTES];

function automatic int op_bytes(lsu_op_t op);
  case (op)
    LSU_LB, LSU_LBU, LSU_SB: return 1;
    LSU_LH, LSU_LHU, LSU_SH: return 2;
    default:                 return 4;
  endcase
endfunction

function automatic logic op_is_store(lsu_op_t op);
  return op inside {LSU_SB, LSU_SH, LSU_SW};
endfunction

// an access is refused unless its address is a multiple of its size.
function automatic logic model_misaligned(lsu_op_t op, addr_t addr);
  return (addr % op_bytes(op)) != 0;
endfunction

function automatic void model_store(lsu_op_t op, addr_t addr, reg_data_t data);
  int base;
  if (model_misaligned(op, addr)) begin
    return;
  end
  base = int'(addr % MODEL_BYTES);
  for (int i = 0; i < op_bytes(op); i++) begin
    model_mem[(base + i) % MODEL_BYTES] = data[8*i +: 8];
  end
endfunction

function automatic reg_data_t model_load(lsu_op_t op, addr_t addr);
  reg_data_t value;
  int        base;
  value = '0;
  base  = int'(addr % MODEL_BYTES);
  for (int i = 0; i < op_bytes(op); i++) begin
    value[8*i +: 8] = model_mem[(base + i) % MODEL_BYTES];
  end
  // signed loads copy the top loaded bit upward.
  if (op == LSU_LB && value[7]) begin
    value[31:8] = '1;
  end
  if (op == LSU_LH && value[15]) begin
    value[31:16] = '1;
  end
  return value;
endfunction

`endif

//--- test/lsu_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_subsys_tb import lsu_pkg::*; ();

  `include "lsu_model.svh"

  localparam int CLK_HALF       = 4;
  localparam int DRIVE_DELAY    = 1;
  localparam int RESET_CYCLES   = 10;
  localparam int ACK_TIMEOUT    = 32;
  localparam int STORE_LOAD_N   = 60;
  localparam int PARTIAL_N      = 40;
  localparam int EXTEND_N       = 16;
  localparam int MISALIGN_N     = 30;
  localparam int HANDSHAKE_N    = 20;
  localparam int TOTAL_ACCESSES = MODEL_BYTES / 4 + 2 * STORE_LOAD_N + 2 * PARTIAL_N +
                                  3 * EXTEND_N + 2 * MISALIGN_N + HANDSHAKE_N;
  localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * 20 + RESET_CYCLES + 20;

  logic     clock;
  logic     reset;
  logic     req_i;
  lsu_req_t req_data_i;
  logic     ack_o;
  lsu_rsp_t rsp_o;

  integer seed;
  int     errors;
  int     checks;
  int     accesses;
  int     tests;

  lsu_subsys i_lsu_subsys (
    .clock      (clock),
    .reset      (reset),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  initial begin
    clock = 1'b0;
    forever #CLK_HALF clock = ~clock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // aligned to bytes and leaving room for a word.
  function automatic addr_t rand_addr(int bytes);
    return addr_t'(rand_below(MODEL_BYTES - 4) & ~(bytes - 1));
  endfunction

  task automatic check_result(input string name, input reg_data_t got, input reg_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_access(input lsu_op_t op, input addr_t addr, input reg_data_t wdata,
                              input int hold, output lsu_rsp_t rsp);
    reg_data_t imm;
    int        waited;
    imm = reg_data_t'($random(seed) % 64);
    @(posedge clock);
    #DRIVE_DELAY;
    req_data_i.op    = op;
    req_data_i.base  = addr - imm;
    req_data_i.imm   = imm;
    req_data_i.wdata = wdata;
    req_i            = 1'b1;
    accesses++;
    waited = 0;
    do begin
      @(posedge clock);
      #DRIVE_DELAY;
      waited++;
    end while (ack_o !== 1'b1 && waited < ACK_TIMEOUT);
    if (ack_o !== 1'b1) begin
      $display("%s at 0x%h got no ack_o within %0d cycles", op.name(), addr, ACK_TIMEOUT);
      errors++;
    end
    rsp = rsp_o;
    // ack and response hold while the core keeps req high.
    repeat (hold) begin
      @(posedge clock);
      #DRIVE_DELAY;
      if (ack_o !== 1'b1 || rsp_o !== rsp) begin
        $display("ack_o or rsp_o changed at %0d ns while req_i was still high", $time);
        errors++;
      end
    end
    req_i  = 1'b0;
    waited = 0;
    do begin
      @(posedge clock);
      #DRIVE_DELAY;
      waited++;
    end while (ack_o !== 1'b0 && waited < ACK_TIMEOUT);
    if (ack_o !== 1'b0) begin
      $display("ack_o did not fall at %0d ns after req_i was dropped", $time);
      errors++;
    end
  endtask

  task automatic checked_access(input lsu_op_t op, input addr_t addr, input reg_data_t wdata,
                                input int hold);
    lsu_rsp_t  rsp;
    logic      exp_err;
    reg_data_t exp_result;
    exp_err    = model_misaligned(op, addr);
    exp_result = model_load(op, addr);
    drive_access(op, addr, wdata, hold, rsp);
    check_err("rsp_o.err", rsp.err, exp_err);
    if (!exp_err && !op_is_store(op)) begin
      check_result("rsp_o.result", rsp.result, exp_result);
    end
    if (op_is_store(op)) begin
      model_store(op, addr, wdata);
    end
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests++;
    $display("test %-12s %s, %0d errors", name,
             (errors == errors_at_start) ? "pass" : "fail", errors - errors_at_start);
  endtask

  task automatic reset_idle();
    int first;
    first = errors;
    repeat (5) begin
      @(posedge clock);
      #DRIVE_DELAY;
      check_err("ack_o", ack_o, 1'b0);
      check_result("rsp_o.result", rsp_o.result, '0);
    end
    report_test("reset_idle", first);
  endtask

  task automatic fill_memory();
    int    first;
    addr_t addr;
    first = errors;
    for (int i = 0; i < MODEL_BYTES / 4; i++) begin
      addr = addr_t'(4 * i);
      checked_access(LSU_SW, addr, addr * 32'h9e37_79b1 + 32'h0f1e_2d3c, 0);
    end
    report_test("fill", first);
  endtask

  task automatic store_then_load();
    int      first;
    lsu_op_t st;
    lsu_op_t ld;
    addr_t   addr;
    first = errors;
    for (int i = 0; i < STORE_LOAD_N; i++) begin
      case (rand_below(3))
        0: begin
          st = LSU_SB;
          ld = (rand_below(2) == 0) ? LSU_LB : LSU_LBU;
        end
        1: begin
          st = LSU_SH;
          ld = (rand_below(2) == 0) ? LSU_LH : LSU_LHU;
        end
        default: begin
          st = LSU_SW;
          ld = LSU_LW;
        end
      endcase
      addr = rand_addr(op_bytes(st));
      checked_access(st, addr, $random(seed), rand_below(4));
      checked_access(ld, addr, '0, rand_below(4));
    end
    report_test("store_load", first);
  endtask

  task automatic partial_stores();
    int      first;
    lsu_op_t st;
    addr_t   addr;
    first = errors;
    for (int i = 0; i < PARTIAL_N; i++) begin
      st   = (rand_below(2) == 0) ? LSU_SB : LSU_SH;
      addr = rand_addr(op_bytes(st));
      checked_access(st, addr, $random(seed), rand_below(4));
      checked_access(LSU_LW, addr & ~addr_t'(3), '0, rand_below(4));
    end
    report_test("partial", first);
  endtask

  task automatic sign_extension();
    int        first;
    lsu_op_t   st;
    lsu_op_t   ld_signed;
    lsu_op_t   ld_unsigned;
    addr_t     addr;
    reg_data_t data;
    first = errors;
    for (int i = 0; i < EXTEND_N; i++) begin
      st          = (i % 2 == 0) ? LSU_SB : LSU_SH;
      ld_signed   = (i % 2 == 0) ? LSU_LB : LSU_LH;
      ld_unsigned = (i % 2 == 0) ? LSU_LBU : LSU_LHU;
      addr        = rand_addr(op_bytes(st));
      data        = $random(seed);
      // alternate the sign bit of the stored value.
      data[8 * op_bytes(st) - 1] = ((i / 2) % 2) == 1;
      checked_access(st, addr, data, rand_below(4));
      checked_access(ld_signed, addr, '0, rand_below(4));
      checked_access(ld_unsigned, addr, '0, rand_below(4));
    end
    report_test("extend", first);
  endtask

  task automatic misaligned_refused();
    int      first;
    lsu_op_t op;
    addr_t   addr;
    first = errors;
    for (int i = 0; i < MISALIGN_N; i++) begin
      case (rand_below(5))
        0:       op = LSU_LH;
        1:       op = LSU_LHU;
        2:       op = LSU_SH;
        3:       op = LSU_LW;
        default: op = LSU_SW;
      endcase
      if (op_bytes(op) == 4) begin
        addr = rand_addr(4) + addr_t'(1 + rand_below(3));
      end else begin
        addr = rand_addr(4) + addr_t'(1 + 2 * rand_below(2));
      end
      checked_access(op, addr, $random(seed), rand_below(4));
      checked_access(LSU_LW, addr & ~addr_t'(3), '0, rand_below(4));
    end
    report_test("misaligned", first);
  endtask

  task automatic long_handshakes();
    int first;
    first = errors;
    for (int i = 0; i < HANDSHAKE_N; i++) begin
      checked_access(LSU_LW, rand_addr(4), '0, rand_below(8));
    end
    report_test("handshake", first);
  endtask

  initial begin
    seed       = 60595;
    errors     = 0;
    checks     = 0;
    accesses   = 0;
    tests      = 0;
    reset      = 1'b1;
    req_i      = 1'b0;
    req_data_i = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    reset_idle();
    fill_memory();
    store_then_load();
    partial_stores();
    sign_extension();
    misaligned_refused();
    long_handshakes();
    $display("summary: %0d tests, %0d accesses, %0d checks, %0d errors",
             tests, accesses, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/lsu_axi_master.sv
logic/axi_sram.sv
logic/lsu_subsys.sv
test/lsu_subsys_tb.sv

//--- Makefile
TOP := lsu_subsys_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
